//--- sim.f
hw/axi_burst_pkg.sv
hw/axi_write_master.sv
hw/axi_read_master.sv
hw/axi_mem_slave.sv
hw/axi_burst_subsys.sv
verif/axi_burst_subsys_checker.sv
verif/axi_burst_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compiles the testbench with Verilator and runs it, run from any directory
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_axi_burst

verilator --binary --timing --assert -Wno-fatal \
	--top-module axi_burst_subsys_tb -f sim.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
	exit 0
fi
exit 1

//--- verif/axi_burst_subsys_tb.sv
// this testbench runs a table of write and read bursts on axi_burst_subsys in order
// later tests rely on memory left by earlier ones, so the table order matters
// write data comes from an LCG and reads are compared beat by beat through rbuf_idx
module axi_burst_subsys_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import axi_burst_pkg::*;

	localparam int MAX_BURST = 16;
	localparam int MEM_WORDS = 64;
	localparam int IDX_W     = $clog2(MAX_BURST);

	logic             clk, rstn;
	logic             wr_start, wbuf_we, wr_busy, wr_done;
	logic             rd_start, rd_busy, rd_done;
	addr_t            wr_addr, rd_addr;
	len_t             wr_len, rd_len;
	id_t              wr_id, rd_id;
	logic [IDX_W-1:0] wbuf_idx, rbuf_idx;
	data_t            wbuf_data, rbuf_data;
	resp_t            wr_resp, rd_resp;

	string t_name[$];
	bit    t_write[$];
	addr_t t_addr[$];
	len_t  t_len[$];
	bit    t_dup[$];
	resp_t t_resp[$];

	data_t       ref_mem [MEM_WORDS];
	data_t       burst_data [MAX_BURST];
	logic [31:0] seed = 32'h9bdc;
	int          cycles = 0;
	int          limit = 0;
	int          wr_done_cnt = 0;
	int          rd_done_cnt = 0;
	int          test_errs;
	int          n_pass = 0;
	int          n_fail = 0;

	axi_burst_subsys #(.MAX_BURST(MAX_BURST), .MEM_WORDS(MEM_WORDS)) DUT (.*);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// the slave rejects any burst whose last word is beyond the memory
	function automatic bit past_end(addr_t a, len_t l);
		return (32'(a[ADDR_W-1:2]) + 32'(l)) >= 32'(MEM_WORDS);
	endfunction

	task automatic add_test(string name, bit wr, addr_t a, len_t l, bit dup, resp_t r);
		t_name.push_back(name);
		t_write.push_back(wr);
		t_addr.push_back(a);
		t_len.push_back(l);
		t_dup.push_back(dup);
		t_resp.push_back(r);
	endtask

	task automatic report_mismatch(string name, string what, logic [31:0] exp, logic [31:0] act);
		$display("FAIL %s %s: expected %h, actual %h", name, what, exp, act);
		test_errs++;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: the tests did not finish within %0d clock cycles", limit);
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (wr_done) begin
			wr_done_cnt++;
		end
		if (rd_done) begin
			rd_done_cnt++;
		end
	end

	task automatic run_write(int i);
		int    word;
		int    done_before;
		data_t d;
		word = int'(t_addr[i][ADDR_W-1:2]);
		for (int b = 0; b <= int'(t_len[i]); b++) begin
			@(posedge clk);
			#1;
			d = next_rand();
			burst_data[b] = d;
			wbuf_we = 1'b1;
			wbuf_idx = IDX_W'(b);
			wbuf_data = d;
		end
		done_before = wr_done_cnt;
		@(posedge clk);
		#1;
		wbuf_we = 1'b0;
		wr_start = 1'b1;
		wr_addr = t_addr[i];
		wr_len = t_len[i];
		wr_id = id_t'(i);
		@(posedge clk);
		#1;
		wr_start = 1'b0;
		if (wr_busy !== 1'b1) begin
			report_mismatch(t_name[i], "wr_busy after start", 32'd1, 32'(wr_busy));
		end
		if (t_dup[i]) begin // new command and new buffer data while the burst is running
			@(posedge clk);
			#1;
			wr_start = 1'b1;
			wr_addr = 32'h40;
			wbuf_we = 1'b1;
			wbuf_idx = '0;
			wbuf_data = ~burst_data[0];
			@(posedge clk);
			#1;
			wr_start = 1'b0;
			wbuf_we = 1'b0;
		end
		while (!wr_done) begin
			@(negedge clk);
		end
		if (wr_resp !== t_resp[i]) begin
			report_mismatch(t_name[i], "wr_resp", 32'(t_resp[i]), 32'(wr_resp));
		end
		if (!past_end(t_addr[i], t_len[i])) begin
			for (int b = 0; b <= int'(t_len[i]); b++) begin
				ref_mem[word + b] = burst_data[b];
			end
		end
		repeat (2) @(negedge clk);
		if (wr_done_cnt - done_before != 1) begin
			report_mismatch(t_name[i], "wr_done pulses", 32'd1, 32'(wr_done_cnt - done_before));
		end
		if (wr_busy !== 1'b0) begin
			report_mismatch(t_name[i], "wr_busy", 32'd0, 32'(wr_busy));
		end
	endtask

	task automatic run_read(int i);
		int    word;
		int    done_before;
		data_t exp;
		word = int'(t_addr[i][ADDR_W-1:2]);
		done_before = rd_done_cnt;
		@(posedge clk);
		#1;
		rd_start = 1'b1;
		rd_addr = t_addr[i];
		rd_len = t_len[i];
		rd_id = id_t'(i);
		@(posedge clk);
		#1;
		rd_start = 1'b0;
		if (rd_busy !== 1'b1) begin
			report_mismatch(t_name[i], "rd_busy after start", 32'd1, 32'(rd_busy));
		end
		if (t_dup[i]) begin
			@(posedge clk);
			#1;
			rd_start = 1'b1;
			rd_addr = 32'h80;
			@(posedge clk);
			#1;
			rd_start = 1'b0;
		end
		while (!rd_done) begin
			@(negedge clk);
		end
		if (rd_resp !== t_resp[i]) begin
			report_mismatch(t_name[i], "rd_resp", 32'(t_resp[i]), 32'(rd_resp));
		end
		for (int b = 0; b <= int'(t_len[i]); b++) begin
			@(posedge clk);
			#1;
			rbuf_idx = IDX_W'(b);
			@(negedge clk);
			if (past_end(t_addr[i], t_len[i])) begin
				exp = '0;
			end else begin
				exp = ref_mem[word + b];
			end
			if (rbuf_data !== exp) begin
				report_mismatch(t_name[i], $sformatf("beat %0d", b), exp, rbuf_data);
			end
		end
		repeat (2) @(negedge clk);
		if (rd_done_cnt - done_before != 1) begin
			report_mismatch(t_name[i], "rd_done pulses", 32'd1, 32'(rd_done_cnt - done_before));
		end
		if (rd_busy !== 1'b0) begin
			report_mismatch(t_name[i], "rd_busy", 32'd0, 32'(rd_busy));
		end
	endtask

	initial begin
		rstn = 1'b0;
		wr_start = 1'b0;
		wr_addr = '0;
		wr_len = '0;
		wr_id = '0;
		wbuf_we = 1'b0;
		wbuf_idx = '0;
		wbuf_data = '0;
		rd_start = 1'b0;
		rd_addr = '0;
		rd_len = '0;
		rd_id = '0;
		rbuf_idx = '0;
		add_test("wr_burst8", 1'b1, 32'h40, 8'd7, 1'b0, RESP_OKAY); // words 16 to 23
		add_test("rd_burst8", 1'b0, 32'h40, 8'd7, 1'b0, RESP_OKAY);
		add_test("wr_full", 1'b1, 32'h50, 8'd15, 1'b0, RESP_OKAY); // overwrites words 20 to 23
		add_test("rd_overlap", 1'b0, 32'h40, 8'd15, 1'b0, RESP_OKAY);
		add_test("wr_fill_hi", 1'b1, 32'hC0, 8'd15, 1'b0, RESP_OKAY);
		add_test("wr_last_word", 1'b1, 32'hFC, 8'd0, 1'b0, RESP_OKAY);
		add_test("rd_last_word", 1'b0, 32'hFC, 8'd0, 1'b0, RESP_OKAY);
		add_test("wr_past_end", 1'b1, 32'hE0, 8'd15, 1'b0, RESP_SLVERR); // ends at word 71
		add_test("rd_past_end", 1'b0, 32'hE0, 8'd15, 1'b0, RESP_SLVERR);
		add_test("rd_hi_intact", 1'b0, 32'hC0, 8'd15, 1'b0, RESP_OKAY);
		add_test("wr_busy_start", 1'b1, 32'h00, 8'd3, 1'b1, RESP_OKAY);
		add_test("rd_busy_start", 1'b0, 32'h00, 8'd3, 1'b1, RESP_OKAY);
		add_test("rd_keep", 1'b0, 32'h40, 8'd3, 1'b0, RESP_OKAY); // the ignored write target
		limit = 8;
		foreach (t_len[i]) begin
			limit += 4 * (int'(t_len[i]) + 1) + 30;
		end
		repeat (8) @(posedge clk);
		#1;
		rstn = 1'b1;
		foreach (t_name[i]) begin
			test_errs = 0;
			if (t_write[i]) begin
				run_write(i);
			end else begin
				run_read(i);
			end
			if (test_errs == 0) begin
				n_pass++;
				$display("test %s ok", t_name[i]);
			end else begin
				n_fail++;
				$display("test %s had %0d mismatches", t_name[i], test_errs);
			end
		end
		$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end
endmodule

//--- verif/axi_burst_subsys_checker.sv
// AXI protocol assertions that bind attaches to every axi_burst_subsys instance
// assumes at most one write burst and one read burst in flight
module axi_burst_subsys_checker (
	input logic                 clk,
	input logic                 rstn,
	input logic                 awvalid, awready, wvalid, wready, wlast, bvalid, bready,
	input logic                 arvalid, arready, rvalid, rready, rlast,
	input logic                 wr_busy, wr_done, rd_busy, rd_done,
	input axi_burst_pkg::addr_t awaddr, araddr,
	input axi_burst_pkg::len_t  awlen, arlen,
	input axi_burst_pkg::id_t   awid, arid, bid, rid,
	input logic [2:0]           awsize, arsize,
	input logic [1:0]           awburst, arburst,
	input axi_burst_pkg::data_t wdata, rdata,
	input axi_burst_pkg::resp_t bresp, rresp
);
	timeunit 1ns;
	timeprecision 100ps;
	import axi_burst_pkg::*;

	len_t w_beat;
	logic w_open; // an AW has been accepted and its last beat not yet sent

	always_ff @(posedge clk) begin
		if (!rstn) begin
			w_beat <= '0;
			w_open <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				w_open <= 1'b1;
			end
			if (wvalid && wready) begin
				w_beat <= wlast ? '0 : w_beat + 8'd1;
				if (wlast) begin
					w_open <= 1'b0;
				end
			end
		end
	end

	a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen)
			&& $stable(awid) && $stable(awsize) && $stable(awburst))
		else $error("awvalid dropped or AW payload changed before awready");
	a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
		else $error("wvalid dropped or W payload changed before wready");
	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid))
		else $error("bvalid dropped or B payload changed before bready");
	a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen)
			&& $stable(arid) && $stable(arsize) && $stable(arburst))
		else $error("arvalid dropped or AR payload changed before arready");
	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
			&& $stable(rlast) && $stable(rid))
		else $error("rvalid dropped or R payload changed before rready");
	a_wlast_beat: assert property (@(posedge clk) disable iff (!rstn)
		wvalid |-> (wlast == (w_beat == awlen)))
		else $error("wlast does not match beat awlen");
	a_w_in_burst: assert property (@(posedge clk) disable iff (!rstn)
		wvalid |-> w_open)
		else $error("wvalid raised outside an accepted write burst");
	a_wr_done: assert property (@(posedge clk) disable iff (!rstn)
		wr_done |-> $past(wr_busy))
		else $error("wr_done pulsed while the write side was idle");
	a_rd_done: assert property (@(posedge clk) disable iff (!rstn)
		rd_done |-> $past(rd_busy))
		else $error("rd_done pulsed while the read side was idle");
endmodule

bind axi_burst_subsys axi_burst_subsys_checker u_checker (.*);

//--- hw/axi_burst_subsys.sv
// AXI4 burst subsystem: a write master and a read master on one memory slave
// the write side and the read side each carry at most one burst at a time
// MAX_BURST sets both master buffers, MEM_WORDS the slave depth
module axi_burst_subsys #(
	parameter int MAX_BURST = axi_burst_pkg::MAX_BURST,
	parameter int MEM_WORDS = 64
) (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         wr_start,
	input  axi_burst_pkg::addr_t         wr_addr,
	input  axi_burst_pkg::len_t          wr_len,
	input  axi_burst_pkg::id_t           wr_id,
	input  logic                         wbuf_we,
	input  logic [$clog2(MAX_BURST)-1:0] wbuf_idx,
	input  axi_burst_pkg::data_t         wbuf_data,
	output logic                         wr_busy,
	output logic                         wr_done,
	output axi_burst_pkg::resp_t         wr_resp,
	input  logic                         rd_start,
	input  axi_burst_pkg::addr_t         rd_addr,
	input  axi_burst_pkg::len_t          rd_len,
	input  axi_burst_pkg::id_t           rd_id,
	input  logic [$clog2(MAX_BURST)-1:0] rbuf_idx,
	output logic                         rd_busy,
	output logic                         rd_done,
	output axi_burst_pkg::resp_t         rd_resp,
	output axi_burst_pkg::data_t         rbuf_data
);
	import axi_burst_pkg::*;

	logic       awvalid, awready;
	addr_t      awaddr;
	id_t        awid;
	len_t       awlen;
	logic [2:0] awsize; // fixed full width, observed by the protocol checker
	logic [1:0] awburst;
	logic       wvalid, wready, wlast;
	data_t      wdata;
	logic       bvalid, bready;
	resp_t      bresp;
	id_t        bid; // echoed by the slave, the master has one burst in flight
	logic       arvalid, arready;
	addr_t      araddr;
	id_t        arid;
	len_t       arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic       rvalid, rready, rlast;
	data_t      rdata;
	resp_t      rresp;
	id_t        rid;

	axi_write_master #(.MAX_BURST(MAX_BURST)) u_wr_master (.*);

	axi_read_master #(.MAX_BURST(MAX_BURST)) u_rd_master (.*);

	axi_mem_slave #(.MEM_WORDS(MEM_WORDS)) u_mem_slave (.*);
endmodule

//--- hw/axi_mem_slave.sv
// AXI4 memory slave with MEM_WORDS words, full-width INCR bursts only
// a burst whose last word is at or past MEM_WORDS gets SLVERR on every beat and on B,
// its writes are dropped and its reads return zero
// one idle cycle follows each accepted address before the first data beat
// write and read channels run independently, a write to the word being read
// while rvalid is held changes rdata, so the host must not overlap them
// MEM_WORDS must be at least 2
module axi_mem_slave #(
	parameter int MEM_WORDS = 64
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic                 awvalid,
	input  axi_burst_pkg::addr_t awaddr,
	input  axi_burst_pkg::id_t   awid,
	input  axi_burst_pkg::len_t  awlen,
	input  logic                 wvalid,
	input  axi_burst_pkg::data_t wdata,
	input  logic                 wlast,
	input  logic                 bready,
	input  logic                 arvalid,
	input  axi_burst_pkg::addr_t araddr,
	input  axi_burst_pkg::id_t   arid,
	input  axi_burst_pkg::len_t  arlen,
	input  logic                 rready,
	output logic                 awready,
	output logic                 wready,
	output logic                 bvalid,
	output axi_burst_pkg::resp_t bresp,
	output axi_burst_pkg::id_t   bid,
	output logic                 arready,
	output logic                 rvalid,
	output axi_burst_pkg::data_t rdata,
	output axi_burst_pkg::resp_t rresp,
	output axi_burst_pkg::id_t   rid,
	output logic                 rlast
);
	import axi_burst_pkg::*;

	localparam int MW_W   = $clog2(MEM_WORDS);
	localparam int WORD_W = ADDR_W - SIZE_FULL;

	data_t             mem [MEM_WORDS];
	wr_state_e         wr_state;
	rd_state_e         rd_state;
	logic [WORD_W-1:0] wr_word;
	logic [WORD_W-1:0] rd_word;
	logic              wr_err;
	logic              rd_err;
	len_t              rd_beat;
	len_t              rd_len;

	// true when the last word of the burst lies outside the memory
	function automatic logic out_of_range(addr_t addr, len_t len);
		logic [ADDR_W:0] last_word;
		last_word = (ADDR_W+1)'(addr[ADDR_W-1:SIZE_FULL]) + (ADDR_W+1)'(len);
		return last_word >= (ADDR_W+1)'(MEM_WORDS);
	endfunction

	assign bresp = wr_err ? RESP_SLVERR : RESP_OKAY;
	assign rresp = rd_err ? RESP_SLVERR : RESP_OKAY;
	assign rdata = rd_err ? '0 : mem[rd_word[MW_W-1:0]];
	assign rlast = (rd_beat == rd_len);

	always_ff @(posedge clk) begin
		if (awvalid && awready) begin
			wr_word <= awaddr[ADDR_W-1:SIZE_FULL];
			wr_err  <= out_of_range(awaddr, awlen);
			bid     <= awid;
		end else if (wvalid && wready) begin
			wr_word <= wr_word + 1'b1;
		end
		if (wvalid && wready && !wr_err) begin
			mem[wr_word[MW_W-1:0]] <= wdata;
		end
		if (arvalid && arready) begin
			rd_word <= araddr[ADDR_W-1:SIZE_FULL];
			rd_err  <= out_of_range(araddr, arlen);
			rd_len  <= arlen;
			rd_beat <= '0;
			rid     <= arid;
		end else if (rvalid && rready) begin
			rd_word <= rd_word + 1'b1;
			rd_beat <= rd_beat + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_state <= WR_IDLE;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					awready <= !(awvalid && awready);
					if (awvalid && awready) begin
						wr_state <= WR_ADDR;
					end
				end
				WR_ADDR: begin // memory latency cycle, no beat accepted yet
					wready   <= 1'b1;
					wr_state <= WR_DATA;
				end
				WR_DATA: begin
					if (wvalid && wlast) begin
						wready   <= 1'b0;
						bvalid   <= 1'b1;
						wr_state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (bready) begin
						bvalid   <= 1'b0;
						wr_state <= WR_IDLE;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_state <= RD_IDLE;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					arready <= !(arvalid && arready);
					if (arvalid && arready) begin
						rd_state <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					rvalid   <= 1'b1;
					rd_state <= RD_DATA;
				end
				RD_DATA: begin
					if (rready && rlast) begin
						rvalid   <= 1'b0;
						rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end
endmodule

//--- hw/axi_read_master.sv
// AXI4 read burst master: one AR, then R beats into a local buffer until rlast
// the buffer holds MAX_BURST beats, so rd_len must stay below MAX_BURST
// rd_resp is the rresp of the final beat, rbuf_data is a combinational readback
module axi_read_master #(
	parameter int MAX_BURST = axi_burst_pkg::MAX_BURST
) (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         rd_start,
	input  axi_burst_pkg::addr_t         rd_addr,
	input  axi_burst_pkg::len_t          rd_len,
	input  axi_burst_pkg::id_t           rd_id,
	input  logic [$clog2(MAX_BURST)-1:0] rbuf_idx,
	input  logic                         arready,
	input  logic                         rvalid,
	input  axi_burst_pkg::data_t         rdata,
	input  axi_burst_pkg::resp_t         rresp,
	input  logic                         rlast,
	output logic                         rd_busy,
	output logic                         rd_done,
	output axi_burst_pkg::resp_t         rd_resp,
	output axi_burst_pkg::data_t         rbuf_data,
	output logic                         arvalid,
	output axi_burst_pkg::addr_t         araddr,
	output axi_burst_pkg::id_t           arid,
	output axi_burst_pkg::len_t          arlen,
	output logic [2:0]                   arsize,
	output logic [1:0]                   arburst,
	output logic                         rready
);
	import axi_burst_pkg::*;

	localparam int IDX_W = $clog2(MAX_BURST);

	data_t     rbuf [MAX_BURST];
	rd_state_e state;
	len_t      beat;

	assign arsize    = SIZE_FULL;
	assign arburst   = BURST_INCR;
	assign rready    = (state == RD_DATA);
	assign rbuf_data = rbuf[rbuf_idx];

	always_ff @(posedge clk) begin
		if (rvalid && rready) begin
			rbuf[beat[IDX_W-1:0]] <= rdata;
		end
		if (rd_start && state == RD_IDLE) begin
			araddr <= rd_addr;
			arid   <= rd_id;
			arlen  <= rd_len;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state   <= RD_IDLE;
			beat    <= '0;
			arvalid <= 1'b0;
			rd_busy <= 1'b0;
			rd_done <= 1'b0;
			rd_resp <= RESP_OKAY;
		end else begin
			rd_done <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (rd_start) begin
						beat    <= '0;
						arvalid <= 1'b1;
						rd_busy <= 1'b1;
						state   <= RD_ADDR;
					end
				end
				RD_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						state   <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (rvalid) begin
						beat <= beat + 1'b1;
						if (rlast) begin // the slave's rlast ends the burst, not the count
							rd_resp <= rresp;
							rd_done <= 1'b1;
							rd_busy <= 1'b0;
							state   <= RD_IDLE;
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end
endmodule

//--- hw/axi_write_master.sv
// AXI4 write burst master: one AW, wr_len+1 W beats from a local buffer, then B
// the buffer holds MAX_BURST beats, so wr_len must stay below MAX_BURST
// buffer writes and start strobes are taken only while the master is idle
// one burst in flight, so bid is not checked
module axi_write_master #(
	parameter int MAX_BURST = axi_burst_pkg::MAX_BURST
) (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         wr_start,
	input  axi_burst_pkg::addr_t         wr_addr,
	input  axi_burst_pkg::len_t          wr_len,
	input  axi_burst_pkg::id_t           wr_id,
	input  logic                         wbuf_we,
	input  logic [$clog2(MAX_BURST)-1:0] wbuf_idx,
	input  axi_burst_pkg::data_t         wbuf_data,
	input  logic                         awready,
	input  logic                         wready,
	input  logic                         bvalid,
	input  axi_burst_pkg::resp_t         bresp,
	output logic                         wr_busy,
	output logic                         wr_done,
	output axi_burst_pkg::resp_t         wr_resp,
	output logic                         awvalid,
	output axi_burst_pkg::addr_t         awaddr,
	output axi_burst_pkg::id_t           awid,
	output axi_burst_pkg::len_t          awlen,
	output logic [2:0]                   awsize,
	output logic [1:0]                   awburst,
	output logic                         wvalid,
	output axi_burst_pkg::data_t         wdata,
	output logic                         wlast,
	output logic                         bready
);
	import axi_burst_pkg::*;

	localparam int IDX_W = $clog2(MAX_BURST);

	data_t     wbuf [MAX_BURST];
	wr_state_e state;
	len_t      beat;

	assign awsize  = SIZE_FULL;
	assign awburst = BURST_INCR;
	assign wvalid  = (state == WR_DATA);
	assign wdata   = wbuf[beat[IDX_W-1:0]]; // stays put until the beat is taken
	assign wlast   = (state == WR_DATA) && (beat == awlen);
	assign bready  = (state == WR_RESP);

	always_ff @(posedge clk) begin
		if (wbuf_we && state == WR_IDLE) begin
			wbuf[wbuf_idx] <= wbuf_data;
		end
		if (wr_start && state == WR_IDLE) begin
			awaddr <= wr_addr;
			awid   <= wr_id;
			awlen  <= wr_len;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state   <= WR_IDLE;
			beat    <= '0;
			awvalid <= 1'b0;
			wr_busy <= 1'b0;
			wr_done <= 1'b0;
			wr_resp <= RESP_OKAY;
		end else begin
			wr_done <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (wr_start) begin
						beat    <= '0;
						awvalid <= 1'b1;
						wr_busy <= 1'b1;
						state   <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (awready) begin
						awvalid <= 1'b0;
						state   <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (wready) begin
						beat <= beat + 1'b1;
						if (wlast) begin
							state <= WR_RESP;
						end
					end
				end
				WR_RESP: begin
					if (bvalid) begin
						wr_resp <= bresp; // held for the host until the next burst ends
						wr_done <= 1'b1;
						wr_busy <= 1'b0;
						state   <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end
endmodule

//--- hw/axi_burst_pkg.sv
// widths, response codes and state encodings shared by the AXI4 burst subsystem
// only full-width INCR bursts exist, so size and burst type are constants
// DATA_W must equal 8 << SIZE_FULL for the byte to word address mapping
package axi_burst_pkg;
	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;
	localparam int ID_W      = 4;
	localparam int MAX_BURST = 16; // default buffer depth in beats

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ID_W-1:0]   id_t;
	typedef logic [7:0]        len_t; // beats minus one
	typedef logic [1:0]        resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam logic [1:0] BURST_INCR = 2'd1;
	localparam logic [2:0] SIZE_FULL  = 3'd2; // log2 of the bytes in one beat

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_e;
endpackage
